//--- tb.f
+incdir+hw
hw/UartPkg.sv
hw/SyncFifo.sv
hw/UartTx.sv
hw/UartRx.sv
hw/UartBusInterface.sv
hw/UartTop.sv
verification/UartTop_asserts.sv
verification/UartTb.sv

//--- Makefile
# Verilator build and run for the UART testbench

SIM := obj_dir/VUartTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f tb.f --top-module UartTb -Mdir obj_dir -o VUartTb

run: compile
	-$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "=== FAIL ===" sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q "=== PASS ===" sim.log; then \
		echo "Simulation stopped before completion"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- verification/UartTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "Uart_defs.svh"

module UartTb;
    import UartPkg::*;

    localparam int StartTimeout = 1000;
    localparam int IdleTimeout  = 200;

    logic                       i_Clk;
    logic                       i_arstN;
    logic                       i_AvSlaveSel;
    logic [`UART_AV_ADDR_W-1:0] i_AvRegAddr;
    logic [3:0]                 i_AvByteEn;
    logic                       i_AvRead;
    logic                       i_AvWrite;
    logic [31:0]                i_AvWriteData;
    logic [31:0]                o_AvReadData;
    logic                       i_UartRx;
    logic                       i_UartNcts;
    logic                       o_UartTx;
    logic                       o_UartNrts;

    // Reference model state
    logic [15:0] cpbModel;
    logic        txEnModel;
    logic        rxEnModel;
    logic        fcEnModel;
    UartByte_t   txExp[$];
    logic [31:0] rxExp[$];

    UartTop u_UartTop (
        .i_Clk         (i_Clk),
        .i_arstN       (i_arstN),
        .i_AvSlaveSel  (i_AvSlaveSel),
        .i_AvRegAddr   (i_AvRegAddr),
        .i_AvByteEn    (i_AvByteEn),
        .i_AvRead      (i_AvRead),
        .i_AvWrite     (i_AvWrite),
        .i_AvWriteData (i_AvWriteData),
        .o_AvReadData  (o_AvReadData),
        .i_UartRx      (i_UartRx),
        .i_UartNcts    (i_UartNcts),
        .o_UartTx      (o_UartTx),
        .o_UartNrts    (o_UartNrts)
    );

    bind UartTop UartTop_asserts u_Asserts (
        .i_Clk        (i_Clk),
        .i_arstN      (i_arstN),
        .i_AvSlaveSel (i_AvSlaveSel),
        .i_AvRead     (i_AvRead),
        .i_AvReadData (o_AvReadData),
        .i_FcEn       (fcEn),
        .i_TxIdle     (txIdle),
        .i_UartTx     (o_UartTx),
        .i_UartNrts   (o_UartNrts)
    );

    always #2 i_Clk = ~i_Clk;

    task automatic check(input string name, input logic [31:0] expVal,
                         input logic [31:0] actVal);
        if (expVal !== actVal) begin
            $display("ERR %s expected %0h actual %0h", name, expVal, actVal);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    task automatic abortRun(input string reason);
        $display("Timed out: %s", reason);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // Bus tasks start and end 1 ns after a rising edge
    task automatic writeReg(input logic [`UART_AV_ADDR_W-1:0] addr, input logic [3:0] be,
                            input logic [31:0] data);
        i_AvSlaveSel  = 1'b1;
        i_AvRegAddr   = addr;
        i_AvByteEn    = be;
        i_AvWrite     = 1'b1;
        i_AvWriteData = data;
        @(posedge i_Clk);
        #1;
        i_AvSlaveSel  = 1'b0;
        i_AvWrite     = 1'b0;
        i_AvByteEn    = 4'h0;
    endtask

    task automatic readReg(input logic [`UART_AV_ADDR_W-1:0] addr, output logic [31:0] data);
        i_AvSlaveSel = 1'b1;
        i_AvRegAddr  = addr;
        i_AvRead     = 1'b1;
        @(posedge i_Clk);
        #1;
        i_AvSlaveSel = 1'b0;
        i_AvRead     = 1'b0;
        // Registered read data with one cycle of latency
        data = o_AvReadData;
    endtask

    task automatic setCtrl(input logic [15:0] cpb, input logic tx, input logic rx,
                           input logic fc);
        cpbModel  = cpb;
        txEnModel = tx;
        rxEnModel = rx;
        fcEnModel = fc;
        writeReg(`UART_ADDR_CTRL, 4'b0111, {10'b0, fc, 3'b000, rx, tx, cpb});
    endtask

    function automatic logic [31:0] ctrlExpect(input logic txIdle, input logic txFull,
                                               input logic rxNotEmpty);
        logic [31:0] w;
        w        = 32'h0;
        w[15:0]  = cpbModel;
        w[16]    = txEnModel;
        w[17]    = rxEnModel;
        w[18]    = txIdle;
        w[19]    = txFull;
        w[20]    = rxNotEmpty;
        w[21]    = fcEnModel;
        return w;
    endfunction

    task automatic waitTxIdle();
        int          tries;
        logic [31:0] rd;
        tries = 0;
        readReg(`UART_ADDR_CTRL, rd);
        while (rd[18] !== 1'b1) begin
            tries++;
            if (tries > IdleTimeout) begin
                abortRun("transmitter never returned to idle");
            end
            readReg(`UART_ADDR_CTRL, rd);
        end
    endtask

    task automatic driveBit(input logic v);
        i_UartRx = v;
        repeat (int'(cpbModel)) @(posedge i_Clk);
        #1;
    endtask

    task automatic sendFrame(input UartByte_t b, input logic stopBit);
        int i;
        driveBit(1'b0);
        for (i = 0; i < 8; i++) begin
            driveBit(b[i]);
        end
        driveBit(stopBit);
        if (!stopBit) begin
            driveBit(1'b1);
        end
        // Gap so the word lands in the FIFO
        repeat (4) @(posedge i_Clk);
        #1;
    endtask

    task automatic receiveByte(input UartByte_t b, input logic stopBit);
        sendFrame(b, stopBit);
        if (rxEnModel && (rxExp.size() < `UART_FIFO_DEPTH)) begin
            rxExp.push_back({23'b0, !stopBit, b});
        end
    endtask

    // Samples TX at mid-bit from the falling start edge
    task automatic captureFrame(output UartByte_t b);
        int waitCnt;
        int i;
        waitCnt = 0;
        while (o_UartTx !== 1'b0) begin
            @(posedge i_Clk);
            #1;
            waitCnt++;
            if (waitCnt > StartTimeout) begin
                abortRun("no start bit appeared on the TX line");
            end
        end
        repeat (int'(cpbModel) / 2) @(posedge i_Clk);
        #1;
        check("tx start bit", 32'h0, 32'(o_UartTx));
        for (i = 0; i < 8; i++) begin
            repeat (int'(cpbModel)) @(posedge i_Clk);
            #1;
            b[i] = o_UartTx;
        end
        repeat (int'(cpbModel)) @(posedge i_Clk);
        #1;
        check("tx stop bit", 32'h1, 32'(o_UartTx));
    endtask

    task automatic expectTxFrames(input int count, input string name);
        int        i;
        UartByte_t got;
        UartByte_t want;
        for (i = 0; i < count; i++) begin
            captureFrame(got);
            want = txExp.pop_front();
            check(name, 32'(want), 32'(got));
        end
    endtask

    task automatic drainRx(input string name);
        logic [31:0] rd;
        logic [31:0] want;
        while (rxExp.size() > 0) begin
            want = rxExp.pop_front();
            readReg(`UART_ADDR_DATA, rd);
            check(name, want, rd);
        end
        readReg(`UART_ADDR_CTRL, rd);
        check("rx not empty flag", 32'h0, 32'(rd[20]));
        readReg(`UART_ADDR_DATA, rd);
        check("rx empty read", 32'h0, rd);
    endtask

    initial begin
        UartByte_t   b;
        logic [31:0] rd;
        logic [31:0] wd;
        logic [3:0]  be;
        int          n;
        int          i;
        int          j;
        int          holdCycles;

        i_Clk         = 1'b0;
        i_arstN       = 1'b0;
        i_AvSlaveSel  = 1'b0;
        i_AvRegAddr   = '0;
        i_AvByteEn    = 4'h0;
        i_AvRead      = 1'b0;
        i_AvWrite     = 1'b0;
        i_AvWriteData = 32'h0;
        i_UartRx      = 1'b1;
        i_UartNcts    = 1'b0;
        cpbModel      = 16'h0;
        txEnModel     = 1'b0;
        rxEnModel     = 1'b0;
        fcEnModel     = 1'b0;
        void'($urandom(32'hd84a_77fc));

        repeat (2) @(posedge i_Clk);
        #1;
        i_arstN = 1'b1;

        // Register access
        readReg(`UART_ADDR_CTRL, rd);
        check("ctrl reset", ctrlExpect(1'b1, 1'b0, 1'b0), rd);
        for (i = 0; i < 12; i++) begin
            be = 4'($urandom);
            wd = $urandom;
            writeReg(`UART_ADDR_CTRL, be, wd);
            if (be[0]) begin
                cpbModel[7:0] = wd[7:0];
            end
            if (be[1]) begin
                cpbModel[15:8] = wd[15:8];
            end
            if (be[2]) begin
                txEnModel = wd[16];
                rxEnModel = wd[17];
                fcEnModel = wd[21];
            end
            readReg(`UART_ADDR_CTRL, rd);
            check("ctrl readback", ctrlExpect(1'b1, 1'b0, 1'b0), rd);
        end

        // Transmit burst overlapping the serial output
        setCtrl(16'(8 + $urandom % 8), 1'b1, 1'b0, 1'b0);
        n = 1 + int'($urandom % 16);
        fork
            begin
                for (j = 0; j < n; j++) begin
                    b = 8'($urandom);
                    txExp.push_back(b);
                    writeReg(`UART_ADDR_DATA, 4'b0001, {24'h0, b});
                end
            end
            begin
                expectTxFrames(n, "tx burst");
            end
        join
        waitTxIdle();
        readReg(`UART_ADDR_CTRL, rd);
        check("tx idle after burst", ctrlExpect(1'b1, 1'b0, 1'b0), rd);

        // Receive
        setCtrl(16'(8 + $urandom % 8), 1'b0, 1'b1, 1'b0);
        n = 1 + int'($urandom % 12);
        for (i = 0; i < n; i++) begin
            receiveByte(8'($urandom), 1'b1);
        end
        drainRx("rx data");

        // Framing error and frames with the receiver disabled
        receiveByte(8'($urandom), 1'b0);
        drainRx("rx frame error");
        setCtrl(cpbModel, 1'b0, 1'b0, 1'b0);
        for (i = 0; i < 3; i++) begin
            receiveByte(8'($urandom), 1'b1);
        end
        drainRx("rx disabled");

        // CTS holds the frame
        setCtrl(16'(8 + $urandom % 8), 1'b1, 1'b1, 1'b1);
        i_UartNcts = 1'b1;
        b = 8'($urandom);
        txExp.push_back(b);
        writeReg(`UART_ADDR_DATA, 4'b0001, {24'h0, b});
        holdCycles = 20 * int'(cpbModel);
        for (i = 0; i < holdCycles; i++) begin
            @(posedge i_Clk);
            #1;
            check("tx held by cts", 32'h1, 32'(o_UartTx));
        end
        i_UartNcts = 1'b0;
        expectTxFrames(1, "tx after cts");
        waitTxIdle();

        // RTS at the threshold
        for (i = 0; i < `UART_RTS_THRESHOLD - 1; i++) begin
            receiveByte(8'($urandom), 1'b1);
            check("nrts below threshold", 32'h0, 32'(o_UartNrts));
        end
        receiveByte(8'($urandom), 1'b1);
        check("nrts at threshold", 32'h1, 32'(o_UartNrts));
        readReg(`UART_ADDR_DATA, rd);
        check("rx data at threshold", rxExp.pop_front(), rd);
        check("nrts after one read", 32'h0, 32'(o_UartNrts));
        drainRx("rx after rts");

        // No RTS without flow control
        setCtrl(cpbModel, 1'b0, 1'b1, 1'b0);
        for (i = 0; i < 15; i++) begin
            receiveByte(8'($urandom), 1'b1);
            check("nrts with fc off", 32'h0, 32'(o_UartNrts));
        end
        drainRx("rx with fc off");

        // TX FIFO overflow keeps the first 16 bytes
        setCtrl(16'(8 + $urandom % 8), 1'b0, 1'b0, 1'b0);
        for (i = 0; i < 20; i++) begin
            b = 8'($urandom);
            if (txExp.size() < `UART_FIFO_DEPTH) begin
                txExp.push_back(b);
            end
            writeReg(`UART_ADDR_DATA, 4'b0001, {24'h0, b});
        end
        readReg(`UART_ADDR_CTRL, rd);
        check("tx full ctrl", ctrlExpect(1'b0, 1'b1, 1'b0), rd);
        setCtrl(cpbModel, 1'b1, 1'b0, 1'b0);
        expectTxFrames(`UART_FIFO_DEPTH, "tx overflow");
        waitTxIdle();
        readReg(`UART_ADDR_CTRL, rd);
        check("tx drained", ctrlExpect(1'b1, 1'b0, 1'b0), rd);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/UartTop_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module UartTop_asserts (
    input wire        i_Clk,
    input wire        i_arstN,
    input wire        i_AvSlaveSel,
    input wire        i_AvRead,
    input wire [31:0] i_AvReadData,
    input wire        i_FcEn,
    input wire        i_TxIdle,
    input wire        i_UartTx,
    input wire        i_UartNrts
);

    // Read data only in the cycle after a sampled read
    readDataIdle: assert property (
        @(posedge i_Clk) disable iff (!i_arstN)
        (i_AvReadData != 32'h0) |-> $past(i_AvSlaveSel && i_AvRead)
    ) else $error("read data nonzero without a read in the previous cycle");

    // RTS is only driven with flow control on
    rtsNeedsFc: assert property (
        @(posedge i_Clk) disable iff (!i_arstN)
        !i_FcEn |-> !i_UartNrts
    ) else $error("nRTS high while flow control is disabled");

    // Idle line level
    txIdleHigh: assert property (
        @(posedge i_Clk) disable iff (!i_arstN)
        i_TxIdle |-> i_UartTx
    ) else $error("TX line low while the transmitter reports idle");

endmodule

`default_nettype wire

//--- hw/UartTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "Uart_defs.svh"

module UartTop (
    input  wire                        i_Clk,
    input  wire                        i_arstN,
    input  wire                        i_AvSlaveSel,
    input  wire [`UART_AV_ADDR_W-1:0]  i_AvRegAddr,
    input  wire [3:0]                  i_AvByteEn,
    input  wire                        i_AvRead,
    input  wire                        i_AvWrite,
    input  wire [31:0]                 i_AvWriteData,
    output logic [31:0]                o_AvReadData,
    input  wire                        i_UartRx,
    input  wire                        i_UartNcts,
    output logic                       o_UartTx,
    output logic                       o_UartNrts
);
    import UartPkg::*;

    ClksPerBit_t clksPerBit;
    logic        fcEn;
    logic        txFifoWrEn;
    UartByte_t   txFifoWrData;
    UartByte_t   txFifoRdData;
    logic        txStart;
    logic        txFifoFull;
    logic        txFifoEmpty;
    logic        txIdle;
    logic        rxValid;
    RxWord_t     rxWord;
    logic        rxFifoWrEn;
    logic        rxFifoRdEn;
    RxWord_t     rxFifoRdData;
    logic        rxFifoEmpty;
    logic        rxFifoProgFull;

    UartBusInterface u_BusInterface (
        .i_Clk            (i_Clk),
        .i_arstN          (i_arstN),
        .i_AvSlaveSel     (i_AvSlaveSel),
        .i_AvRegAddr      (i_AvRegAddr),
        .i_AvByteEn       (i_AvByteEn),
        .i_AvRead         (i_AvRead),
        .i_AvWrite        (i_AvWrite),
        .i_AvWriteData    (i_AvWriteData),
        .o_AvReadData     (o_AvReadData),
        .o_ClksPerBit     (clksPerBit),
        .o_FcEn           (fcEn),
        .o_TxFifoWrEn     (txFifoWrEn),
        .o_TxFifoWrData   (txFifoWrData),
        .o_TxStart        (txStart),
        .o_RxFifoWrEn     (rxFifoWrEn),
        .o_RxFifoRdEn     (rxFifoRdEn),
        .o_UartNrts       (o_UartNrts),
        .i_TxFifoFull     (txFifoFull),
        .i_TxFifoEmpty    (txFifoEmpty),
        .i_TxIdle         (txIdle),
        .i_RxValid        (rxValid),
        .i_RxFifoRdData   (rxFifoRdData),
        .i_RxFifoEmpty    (rxFifoEmpty),
        .i_RxFifoProgFull (rxFifoProgFull)
    );

    // TX FIFO is read by the launch strobe
    SyncFifo #(
        .T           (UartByte_t),
        .Depth       (`UART_FIFO_DEPTH),
        .ProgFullThr (`UART_FIFO_DEPTH),
        .Fwft        (1'b0)
    ) u_TxFifo (
        .i_Clk      (i_Clk),
        .i_arstN    (i_arstN),
        .i_WrEn     (txFifoWrEn),
        .i_WrData   (txFifoWrData),
        .i_RdEn     (txStart),
        .o_RdData   (txFifoRdData),
        .o_Full     (txFifoFull),
        .o_Empty    (txFifoEmpty),
        .o_ProgFull ()
    );

    SyncFifo #(
        .T           (RxWord_t),
        .Depth       (`UART_FIFO_DEPTH),
        .ProgFullThr (`UART_RTS_THRESHOLD),
        .Fwft        (1'b1)
    ) u_RxFifo (
        .i_Clk      (i_Clk),
        .i_arstN    (i_arstN),
        .i_WrEn     (rxFifoWrEn),
        .i_WrData   (rxWord),
        .i_RdEn     (rxFifoRdEn),
        .o_RdData   (rxFifoRdData),
        .o_Full     (),
        .o_Empty    (rxFifoEmpty),
        .o_ProgFull (rxFifoProgFull)
    );

    UartTx u_UartTx (
        .i_Clk        (i_Clk),
        .i_arstN      (i_arstN),
        .i_ClksPerBit (clksPerBit),
        .i_FcEn       (fcEn),
        .i_TxStart    (txStart),
        .i_Data       (txFifoRdData),
        .i_UartNcts   (i_UartNcts),
        .o_TxIdle     (txIdle),
        .o_UartTx     (o_UartTx)
    );

    UartRx u_UartRx (
        .i_Clk        (i_Clk),
        .i_arstN      (i_arstN),
        .i_ClksPerBit (clksPerBit),
        .i_UartRx     (i_UartRx),
        .o_RxValid    (rxValid),
        .o_RxWord     (rxWord)
    );

endmodule

`default_nettype wire

//--- hw/UartBusInterface.sv
`timescale 1ns/1ps
`default_nettype none

`include "Uart_defs.svh"

module UartBusInterface (
    input  wire                        i_Clk,
    input  wire                        i_arstN,

    // Avalon-style slave
    input  wire                        i_AvSlaveSel,
    input  wire [`UART_AV_ADDR_W-1:0]  i_AvRegAddr,
    input  wire [3:0]                  i_AvByteEn,
    input  wire                        i_AvRead,
    input  wire                        i_AvWrite,
    input  wire [31:0]                 i_AvWriteData,
    output logic [31:0]                o_AvReadData,

    // Control towards the UART logic
    output UartPkg::ClksPerBit_t       o_ClksPerBit,
    output logic                       o_FcEn,
    output logic                       o_TxFifoWrEn,
    output UartPkg::UartByte_t         o_TxFifoWrData,
    output logic                       o_TxStart,
    output logic                       o_RxFifoWrEn,
    output logic                       o_RxFifoRdEn,
    output logic                       o_UartNrts,

    // Status
    input  wire                        i_TxFifoFull,
    input  wire                        i_TxFifoEmpty,
    input  wire                        i_TxIdle,
    input  wire                        i_RxValid,
    input  wire UartPkg::RxWord_t      i_RxFifoRdData,
    input  wire                        i_RxFifoEmpty,
    input  wire                        i_RxFifoProgFull
);
    import UartPkg::*;

    ClksPerBit_t clksPerBit;
    logic        txEn;
    logic        rxEn;
    logic        fcEn;
    logic        ctrlSel;
    logic        dataSel;
    logic [31:0] ctrlWord;
    logic [31:0] dataWord;

    assign ctrlSel = i_AvSlaveSel && (i_AvRegAddr == `UART_ADDR_CTRL);
    assign dataSel = i_AvSlaveSel && (i_AvRegAddr == `UART_ADDR_DATA);

    assign o_ClksPerBit = clksPerBit;
    assign o_FcEn       = fcEn;

    // DATA write pushes on the sampling edge
    assign o_TxFifoWrEn   = dataSel && i_AvWrite && i_AvByteEn[0];
    assign o_TxFifoWrData = i_AvWriteData[7:0];

    // DATA read pops the FWFT head on the same edge it is captured
    assign o_RxFifoRdEn = dataSel && i_AvRead && !i_RxFifoEmpty;
    assign o_RxFifoWrEn = i_RxValid && rxEn;

    assign o_UartNrts = fcEn ? i_RxFifoProgFull : 1'b0;

    assign ctrlWord = {10'b0, fcEn, !i_RxFifoEmpty, i_TxFifoFull,
                       i_TxFifoEmpty && i_TxIdle, rxEn, txEn, clksPerBit};
    assign dataWord = {23'b0, i_RxFifoRdData.frameErr, i_RxFifoRdData.data};

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            clksPerBit <= '0;
            txEn       <= 1'b0;
            rxEn       <= 1'b0;
            fcEn       <= 1'b0;
        end else if (ctrlSel && i_AvWrite) begin
            if (i_AvByteEn[0]) begin
                clksPerBit[7:0] <= i_AvWriteData[7:0];
            end
            if (i_AvByteEn[1]) begin
                clksPerBit[15:8] <= i_AvWriteData[15:8];
            end
            if (i_AvByteEn[2]) begin
                txEn <= i_AvWriteData[`UART_CTRL_TXEN_BIT];
                rxEn <= i_AvWriteData[`UART_CTRL_RXEN_BIT];
                fcEn <= i_AvWriteData[`UART_CTRL_FCEN_BIT];
            end
        end
    end

    // Read data valid only in the cycle after the strobe
    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_AvReadData <= '0;
        end else if (ctrlSel && i_AvRead) begin
            o_AvReadData <= ctrlWord;
        end else if (o_RxFifoRdEn) begin
            o_AvReadData <= dataWord;
        end else begin
            o_AvReadData <= '0;
        end
    end

    // Launch strobe never fires two cycles in a row
    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            o_TxStart <= 1'b0;
        end else begin
            o_TxStart <= !i_TxFifoEmpty && txEn && i_TxIdle && !o_TxStart;
        end
    end

endmodule

`default_nettype wire

//--- hw/UartRx.sv
`timescale 1ns/1ps
`default_nettype none

module UartRx (
    input  wire                       i_Clk,
    input  wire                       i_arstN,
    input  wire UartPkg::ClksPerBit_t i_ClksPerBit,
    input  wire                       i_UartRx,
    output logic                      o_RxValid,
    output UartPkg::RxWord_t          o_RxWord
);
    import UartPkg::*;

    typedef enum logic [1:0] {
        StIdle,
        StStart,
        StData,
        StStop
    } RxState_t;

    RxState_t    state;
    ClksPerBit_t cnt;
    ClksPerBit_t halfPeriod;
    UartByte_t   shiftReg;
    logic [2:0]  bitIdx;
    logic        rxMeta;
    logic        rxSync;
    logic        rxPrev;
    logic        halfDone;
    logic        bitDone;
    logic        sampleData;
    logic        sampleStop;

    assign halfPeriod = i_ClksPerBit >> 1;
    assign halfDone   = ({1'b0, cnt} + 17'd1) >= {1'b0, halfPeriod};
    assign bitDone    = ({1'b0, cnt} + 17'd1) >= {1'b0, i_ClksPerBit};
    assign sampleData = (state == StData) && bitDone;
    assign sampleStop = (state == StStop) && bitDone;

    // Two-flop synchroniser and an edge-detect stage
    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            rxMeta <= 1'b1;
            rxSync <= 1'b1;
            rxPrev <= 1'b1;
        end else begin
            rxMeta <= i_UartRx;
            rxSync <= rxMeta;
            rxPrev <= rxSync;
        end
    end

    // LSB arrives first
    always_ff @(posedge i_Clk) begin
        if (sampleData) begin
            shiftReg <= {rxSync, shiftReg[7:1]};
        end
        if (sampleStop) begin
            o_RxWord.data     <= shiftReg;
            o_RxWord.frameErr <= !rxSync;
        end
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            state     <= StIdle;
            cnt       <= '0;
            bitIdx    <= '0;
            o_RxValid <= 1'b0;
        end else begin
            o_RxValid <= sampleStop;
            case (state)
                StIdle: begin
                    cnt <= '0;
                    if (rxPrev && !rxSync) begin
                        state <= StStart;
                    end
                end
                StStart: begin
                    if (halfDone) begin
                        cnt    <= '0;
                        bitIdx <= '0;
                        // Line back high at mid-bit means a glitch
                        state  <= rxSync ? StIdle : StData;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                StData: begin
                    if (bitDone) begin
                        cnt <= '0;
                        if (bitIdx == 3'd7) begin
                            state <= StStop;
                        end else begin
                            bitIdx <= bitIdx + 3'd1;
                        end
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                StStop: begin
                    if (bitDone) begin
                        cnt   <= '0;
                        state <= StIdle;
                    end else begin
                        cnt <= cnt + 16'd1;
                    end
                end
                default: begin
                    state <= StIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/UartTx.sv
`timescale 1ns/1ps
`default_nettype none

module UartTx (
    input  wire                  i_Clk,
    input  wire                  i_arstN,
    input  wire UartPkg::ClksPerBit_t i_ClksPerBit,
    input  wire                  i_FcEn,
    input  wire                  i_TxStart,
    input  wire UartPkg::UartByte_t   i_Data,
    input  wire                  i_UartNcts,
    output logic                 o_TxIdle,
    output logic                 o_UartTx
);
    import UartPkg::*;

    typedef enum logic [2:0] {
        StIdle,
        StLoad,
        StWaitCts,
        StStart,
        StData,
        StStop
    } TxState_t;

    TxState_t    state;
    ClksPerBit_t cnt;
    UartByte_t   shiftReg;
    logic [2:0]  bitIdx;
    logic        bitDone;
    logic        ctsBlock;
    logic        shiftNow;

    assign bitDone  = ({1'b0, cnt} + 17'd1) >= {1'b0, i_ClksPerBit};
    assign ctsBlock = i_FcEn && i_UartNcts;
    assign shiftNow = bitDone && ((state == StStart) ||
                                  ((state == StData) && (bitIdx != 3'd7)));

    // Busy as soon as the launch strobe is seen
    assign o_TxIdle = (state == StIdle) && !i_TxStart;

    // FIFO data is valid the cycle after the strobe
    always_ff @(posedge i_Clk) begin
        if (state == StLoad) begin
            shiftReg <= i_Data;
        end else if (shiftNow) begin
            shiftReg <= shiftReg >> 1;
        end
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            state    <= StIdle;
            cnt      <= '0;
            bitIdx   <= '0;
            o_UartTx <= 1'b1;
        end else begin
            if ((state == StStart) || (state == StData) || (state == StStop)) begin
                cnt <= bitDone ? '0 : cnt + 16'd1;
            end else begin
                cnt <= '0;
            end

            if (shiftNow) begin
                o_UartTx <= shiftReg[0];
            end

            case (state)
                StIdle: begin
                    if (i_TxStart) begin
                        state <= StLoad;
                    end
                end
                StLoad, StWaitCts: begin
                    // Frame starts only with CTS asserted
                    if (!ctsBlock) begin
                        state    <= StStart;
                        o_UartTx <= 1'b0;
                    end else begin
                        state <= StWaitCts;
                    end
                end
                StStart: begin
                    if (bitDone) begin
                        state  <= StData;
                        bitIdx <= '0;
                    end
                end
                StData: begin
                    if (bitDone) begin
                        if (bitIdx == 3'd7) begin
                            state    <= StStop;
                            o_UartTx <= 1'b1;
                        end else begin
                            bitIdx <= bitIdx + 3'd1;
                        end
                    end
                end
                StStop: begin
                    if (bitDone) begin
                        state <= StIdle;
                    end
                end
                default: begin
                    state    <= StIdle;
                    o_UartTx <= 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/SyncFifo.sv
`timescale 1ns/1ps
`default_nettype none

module SyncFifo #(
    parameter type T           = logic [7:0],
    parameter int  Depth       = 16,
    parameter int  ProgFullThr = Depth - 2,
    parameter bit  Fwft        = 1'b0
) (
    input  wire   i_Clk,
    input  wire   i_arstN,
    input  wire   i_WrEn,
    input  wire T i_WrData,
    input  wire   i_RdEn,
    output T      o_RdData,
    output logic  o_Full,
    output logic  o_Empty,
    output logic  o_ProgFull
);

    localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW = $clog2(Depth + 1);

    T mem [Depth];

    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic [CntW-1:0] countNext;
    logic            doWr;
    logic            doRd;

    function automatic logic [PtrW-1:0] ptrInc(input logic [PtrW-1:0] p);
        ptrInc = (p == PtrW'(Depth - 1)) ? '0 : p + 1'b1;
    endfunction

    // Push when full and pop when empty are dropped
    assign doWr = i_WrEn && !o_Full;
    assign doRd = i_RdEn && !o_Empty;

    always_comb begin
        case ({doWr, doRd})
            2'b10:   countNext = count + 1'b1;
            2'b01:   countNext = count - 1'b1;
            default: countNext = count;
        endcase
    end

    always_ff @(posedge i_Clk) begin
        if (doWr) begin
            mem[wrPtr] <= i_WrData;
        end
    end

    always_ff @(posedge i_Clk or negedge i_arstN) begin
        if (!i_arstN) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            o_Full     <= 1'b0;
            o_Empty    <= 1'b1;
            o_ProgFull <= 1'b0;
        end else begin
            if (doWr) begin
                wrPtr <= ptrInc(wrPtr);
            end
            if (doRd) begin
                rdPtr <= ptrInc(rdPtr);
            end
            count      <= countNext;
            o_Full     <= (countNext == CntW'(Depth));
            o_Empty    <= (countNext == '0);
            o_ProgFull <= (countNext >= CntW'(ProgFullThr));
        end
    end

    generate
        if (Fwft) begin : g_Fwft
            // Head shows without a read
            assign o_RdData = mem[rdPtr];
        end else begin : g_Std
            always_ff @(posedge i_Clk) begin
                if (doRd) begin
                    o_RdData <= mem[rdPtr];
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

//--- hw/UartPkg.sv
`default_nettype none

package UartPkg;

    // One serial character
    typedef logic [7:0] UartByte_t;

    // Clock cycles per bit period
    typedef logic [15:0] ClksPerBit_t;

    // Received character plus its stop-bit check
    // frameErr is set when the stop bit sampled low
    typedef struct packed {
        UartByte_t data;
        logic      frameErr;
    } RxWord_t;

endpackage

`default_nettype wire

//--- hw/Uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// Entries in each FIFO
`define UART_FIFO_DEPTH 16

// RX FIFO fill level that raises programmable-full
`define UART_RTS_THRESHOLD 14

// Register word address width
`define UART_AV_ADDR_W 2

// Register map
`define UART_ADDR_CTRL 2'd0
`define UART_ADDR_DATA 2'd1

// CTRL bit positions
`define UART_CTRL_TXEN_BIT 16
`define UART_CTRL_RXEN_BIT 17
`define UART_CTRL_FCEN_BIT 21

`endif
